//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module ctrlRegTb -f list.f

sim:
	verilator --binary --timing --assert --top-module ctrlRegTb -Mdir obj_dir -f list.f
	./obj_dir/VctrlRegTb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- common/crPkg.sv
package crPkg;

	// Control register IDs as seen on the read and write-back buses
	typedef enum logic [4:0]
	{
		crSr	= 5'h00,
		crExsr	= 5'h01,
		crPc	= 5'h02,
		crLr	= 5'h03,
		crVbr	= 5'h04,
		crSpc	= 5'h05,
		crSsp	= 5'h06,
		crGbr	= 5'h07,
		crTbr	= 5'h08,
		crTea	= 5'h09,
		crTtb	= 5'h0A,
		crMmcr	= 5'h0B,
		crSttb	= 5'h0C,
		crKrr	= 5'h0D,
		crImm	= 5'h1E,	// Immediate slot, reads zero
		crZzr	= 5'h1F		// Zero register
	} crId_t;

	localparam int addrWidth = 48;	// Virtual address width
	localparam int wordWidth = 64;

	// Supervisor mode only
	localparam logic [wordWidth-1:0] srResetValue = 64'h0000_0000_4000_0000;

	typedef struct packed
	{
		logic [31:0]	reservedHi;
		logic			reserved31;
		logic			supervisor;			// Bit 30
		logic			blockInterrupts;	// Bit 29
		logic [24:0]	reservedMid;
		logic [2:0]		reservedLo;
		logic			flagT;				// Bit 0
	} srFields_t;

	// Same SR word, raw for storage and by field for mode changes
	typedef union packed
	{
		logic [wordWidth-1:0]	raw;
		srFields_t				fields;
	} srWord_t;

endpackage

//--- common/trapPkg.sv
package trapPkg;

	// Cause codes, also the vector slot index
	typedef enum logic [3:0]
	{
		causeReset		= 4'h0,
		causeFault		= 4'h1,
		causeSyscall	= 4'h2,
		causeInterrupt	= 4'h3
	} trapCause_t;

	// Each vector slot is 16 bytes
	localparam int vectorShift = 4;

	// Byte offset of a cause's slot from VBR
	function automatic logic [vectorShift+3:0] vectorOffset
	(
		input trapCause_t cause
	);
		return {cause, {vectorShift{1'b0}}};
	endfunction

endpackage

//--- crFile/crFile.sv
`timescale 1ns/1ps

module crFile
(
	input	logic							clock,
	input	logic							reset,
	input	logic							hold,

	input	crPkg::crId_t					readId,
	output	logic [crPkg::wordWidth-1:0]	readVal,

	input	crPkg::crId_t					ex1Id,
	input	logic [crPkg::wordWidth-1:0]	ex1Val,
	input	crPkg::crId_t					ex2Id,
	input	logic [crPkg::wordWidth-1:0]	ex2Val,

	input	logic [crPkg::addrWidth-1:0]	nextPc,
	input	logic [crPkg::addrWidth-1:0]	nextLr,
	input	logic [crPkg::addrWidth-1:0]	nextSpc,
	input	logic [crPkg::addrWidth-1:0]	nextTea,
	input	logic [crPkg::wordWidth-1:0]	nextSr,
	input	logic [crPkg::wordWidth-1:0]	nextExsr,

	output	logic [crPkg::addrWidth-1:0]	pc,
	output	logic [crPkg::addrWidth-1:0]	lr,
	output	logic [crPkg::addrWidth-1:0]	spc,
	output	logic [crPkg::addrWidth-1:0]	vbr,
	output	logic [crPkg::addrWidth-1:0]	tea,
	output	logic [crPkg::wordWidth-1:0]	sr,
	output	logic [crPkg::wordWidth-1:0]	exsr
);

	import crPkg::*;

	srWord_t				srReg;
	logic [wordWidth-1:0]	exsrReg;
	logic [wordWidth-1:0]	mmcrReg;
	logic [wordWidth-1:0]	krrReg;

	logic [addrWidth-1:0]	pcReg;
	logic [addrWidth-1:0]	lrReg;
	logic [addrWidth-1:0]	vbrReg;
	logic [addrWidth-1:0]	spcReg;
	logic [addrWidth-1:0]	sspReg;
	logic [addrWidth-1:0]	gbrReg;
	logic [addrWidth-1:0]	tbrReg;
	logic [addrWidth-1:0]	teaReg;
	logic [addrWidth-1:0]	ttbReg;
	logic [addrWidth-1:0]	sttbReg;

	logic [addrWidth-1:0]	ex2Addr;	// Write-back value cut to address width
	logic [wordWidth-1:0]	storedVal;

	assign ex2Addr = ex2Val[addrWidth-1:0];

	assign pc	= pcReg;
	assign lr	= lrReg;
	assign spc	= spcReg;
	assign vbr	= vbrReg;
	assign tea	= teaReg;
	assign sr	= srReg.raw;
	assign exsr	= exsrReg;

	always_comb
	begin
		case (readId)
			crSr:		storedVal = srReg.raw;
			crExsr:		storedVal = exsrReg;
			crPc:		storedVal = wordWidth'(pcReg);	// Zero-extended
			crLr:		storedVal = wordWidth'(lrReg);
			crVbr:		storedVal = wordWidth'(vbrReg);
			crSpc:		storedVal = wordWidth'(spcReg);
			crSsp:		storedVal = wordWidth'(sspReg);
			crGbr:		storedVal = wordWidth'(gbrReg);
			crTbr:		storedVal = wordWidth'(tbrReg);
			crTea:		storedVal = wordWidth'(teaReg);
			crTtb:		storedVal = wordWidth'(ttbReg);
			crMmcr:		storedVal = mmcrReg;
			crSttb:		storedVal = wordWidth'(sttbReg);
			crKrr:		storedVal = krrReg;
			default:	storedVal = '0;	// Also crImm and crZzr
		endcase

		// Forward in-flight results, EX1 is younger so it wins
		readVal = storedVal;
		if (readId != crImm && readId != crZzr)
		begin
			if (readId == ex2Id)
				readVal = ex2Val;
			if (readId == ex1Id)
				readVal = ex1Val;
		end
	end

	// Registers with a defined reset state
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pcReg		<= '0;
			lrReg		<= '0;
			vbrReg		<= '0;
			gbrReg		<= '0;
			tbrReg		<= '0;
			mmcrReg		<= '0;
			krrReg		<= '0;
			srReg.raw	<= srResetValue;
		end
		else if (!hold)
		begin
			pcReg		<= nextPc;	// No write-back path to PC
			lrReg		<= (ex2Id == crLr) ? ex2Addr : nextLr;
			srReg.raw	<= (ex2Id == crSr) ? ex2Val : nextSr;
			vbrReg		<= (ex2Id == crVbr) ? ex2Addr : vbrReg;
			gbrReg		<= (ex2Id == crGbr) ? ex2Addr : gbrReg;
			tbrReg		<= (ex2Id == crTbr) ? ex2Addr : tbrReg;
			mmcrReg		<= (ex2Id == crMmcr) ? ex2Val : mmcrReg;
			krrReg		<= (ex2Id == crKrr) ? ex2Val : krrReg;
		end
	end

	// Undefined until software or a trap writes them
	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			exsrReg	<= (ex2Id == crExsr) ? ex2Val : nextExsr;
			spcReg	<= (ex2Id == crSpc) ? ex2Addr : nextSpc;
			teaReg	<= (ex2Id == crTea) ? ex2Addr : nextTea;
			sspReg	<= (ex2Id == crSsp) ? ex2Addr : sspReg;
			ttbReg	<= (ex2Id == crTtb) ? ex2Addr : ttbReg;
			sttbReg	<= (ex2Id == crSttb) ? ex2Addr : sttbReg;
		end
	end

	// A held cycle must not move PC, even with a trap pending upstream
	holdFreezes: assert property (@(posedge clock) disable iff (reset)
		hold |=> (pcReg == $past(pcReg)) && (vbrReg == $past(vbrReg)))
		else $error("PC or VBR changed across a held cycle");

	readIdKnown: assert property (@(posedge clock) !reset |-> !$isunknown(readId))
		else $error("Read ID is unknown");

endmodule

//--- list.f
common/crPkg.sv
common/trapPkg.sv
crFile/crFile.sv
trap/trapUnit.sv
rtl/ctrlRegTop.sv
verif/ctrlRegChecker.sv
verif/ctrlRegTb.sv

//--- rtl/ctrlRegTop.sv
`timescale 1ns/1ps

module ctrlRegTop
(
	input	logic							clock,
	input	logic							reset,
	input	logic							hold,

	input	logic [crPkg::addrWidth-1:0]	pcNext,
	input	logic [crPkg::addrWidth-1:0]	lrNext,

	input	logic							trapReq,
	input	trapPkg::trapCause_t			trapCause,
	input	logic [crPkg::addrWidth-1:0]	trapAddr,
	input	logic							rteReq,

	input	crPkg::crId_t					readId,
	output	logic [crPkg::wordWidth-1:0]	readVal,

	input	crPkg::crId_t					ex1Id,
	input	logic [crPkg::wordWidth-1:0]	ex1Val,
	input	crPkg::crId_t					ex2Id,
	input	logic [crPkg::wordWidth-1:0]	ex2Val,

	output	logic [crPkg::addrWidth-1:0]	pc,
	output	logic [crPkg::wordWidth-1:0]	sr,
	output	logic [crPkg::addrWidth-1:0]	vbr
);

	import crPkg::*;

	logic [addrWidth-1:0]	spc;
	logic [addrWidth-1:0]	tea;
	logic [wordWidth-1:0]	exsr;

	// Trap sequencer results headed for the register file
	logic [addrWidth-1:0]	nextPc;
	logic [addrWidth-1:0]	nextSpc;
	logic [addrWidth-1:0]	nextTea;
	logic [wordWidth-1:0]	nextSr;
	logic [wordWidth-1:0]	nextExsr;

	trapUnit trapUnit_i
	(
		.pcNext(pcNext), .trapAddr(trapAddr), .pc(pc), .spc(spc), .tea(tea), .vbr(vbr),
		.sr(sr), .exsr(exsr), .trapReq(trapReq), .rteReq(rteReq), .trapCause(trapCause),
		.nextPc(nextPc), .nextSpc(nextSpc), .nextTea(nextTea),
		.nextSr(nextSr), .nextExsr(nextExsr)
	);

	crFile crFile_i
	(
		.clock(clock), .reset(reset), .hold(hold),
		.readId(readId), .readVal(readVal),
		.ex1Id(ex1Id), .ex1Val(ex1Val), .ex2Id(ex2Id), .ex2Val(ex2Val),
		.nextPc(nextPc), .nextLr(lrNext), .nextSpc(nextSpc), .nextTea(nextTea),
		.nextSr(nextSr), .nextExsr(nextExsr),
		.pc(pc), .lr(), .spc(spc), .vbr(vbr), .tea(tea), .sr(sr), .exsr(exsr)
	);

endmodule

//--- trap/trapUnit.sv
`timescale 1ns/1ps

module trapUnit
(
	input	logic [crPkg::addrWidth-1:0]	pcNext,
	input	logic [crPkg::addrWidth-1:0]	trapAddr,
	input	logic [crPkg::addrWidth-1:0]	pc,
	input	logic [crPkg::addrWidth-1:0]	spc,
	input	logic [crPkg::addrWidth-1:0]	tea,
	input	logic [crPkg::addrWidth-1:0]	vbr,
	input	logic [crPkg::wordWidth-1:0]	sr,
	input	logic [crPkg::wordWidth-1:0]	exsr,

	input	logic							trapReq,
	input	logic							rteReq,
	input	trapPkg::trapCause_t			trapCause,

	output	logic [crPkg::addrWidth-1:0]	nextPc,
	output	logic [crPkg::addrWidth-1:0]	nextSpc,
	output	logic [crPkg::addrWidth-1:0]	nextTea,
	output	logic [crPkg::wordWidth-1:0]	nextSr,
	output	logic [crPkg::wordWidth-1:0]	nextExsr
);

	import crPkg::*;
	import trapPkg::*;

	srWord_t				trapSr;		// SR as it looks after trap entry
	logic [addrWidth-1:0]	vectorPc;

	// Enter supervisor mode with interrupts blocked
	always_comb
	begin
		trapSr.raw = sr;
		trapSr.fields.supervisor = 1'b1;
		trapSr.fields.blockInterrupts = 1'b1;
	end

	assign vectorPc = vbr + addrWidth'(vectorOffset(trapCause));

	always_comb
	begin
		// Default is the plain sequential flow
		nextPc		= pcNext;
		nextSr		= sr;
		nextExsr	= exsr;
		nextSpc		= spc;
		nextTea		= tea;

		if (trapReq)
		begin
			nextPc		= vectorPc;
			nextSr		= trapSr.raw;
			nextExsr	= sr;		// Save state for the return
			nextSpc		= pc;
			nextTea		= trapAddr;
		end
		else if (rteReq)
		begin
			nextPc	= spc;
			nextSr	= exsr;
		end
	end

	// The pipeline never issues a trap and a return in the same cycle
	always_comb
	begin
		trapRteExclusive: assert #0 (!(trapReq === 1'b1 && rteReq === 1'b1))
			else $error("trapReq and rteReq both high");
	end

endmodule

//--- verif/ctrlGolden.txt
// op cause readId ex1Id ex1Val ex2Id ex2Val pcNext trapAddr expRead expPc expSr
// op 0 read 1 write 2 trap 3 rte 4 hold 5 hold+trap f end, pc and sr as seen during the step
0 0 00 1f 0 1f 0 0 0 40000000 0 40000000
0 0 02 1f 0 1f 0 0 0 0 0 40000000
0 0 04 1f 0 1f 0 0 0 0 0 40000000
0 0 07 1f 0 1f 0 100 0 0 0 40000000
1 0 1f 1f 0 04 ffff000000001000 104 0 0 100 40000000
1 0 04 1f 0 07 abcd123456789abc 108 0 1000 104 40000000
1 0 07 1f 0 08 2000 10c 0 123456789abc 108 40000000
1 0 08 1f 0 06 7ff0 110 0 2000 10c 40000000
1 0 06 1f 0 0b 8000000000000005 114 0 7ff0 110 40000000
0 0 0b 1f 0 1f 0 118 0 8000000000000005 114 40000000
0 0 07 07 1111 07 2222 11c 0 1111 118 40000000
0 0 08 1f 0 08 3333 120 0 3333 11c 40000000
0 0 1f 1f 5555 1f 6666 124 0 0 120 40000000
0 0 07 1f 0 1f 0 128 0 2222 124 40000000
2 2 1f 1f 0 1f 0 12c deadbeef0040 0 128 40000000
0 0 05 1f 0 1f 0 1024 0 128 1020 60000000
0 0 01 1f 0 1f 0 1028 0 40000000 1024 60000000
0 0 09 1f 0 1f 0 102c 0 deadbeef0040 1028 60000000
3 0 00 1f 0 1f 0 1030 0 60000000 102c 60000000
0 0 02 1f 0 1f 0 12c 0 128 128 40000000
5 1 1f 1f 0 04 9000 200 1 0 12c 40000000
0 0 04 1f 0 1f 0 130 0 1000 12c 40000000
0 0 05 1f 0 1f 0 134 0 128 130 40000000
4 0 1f 1f 0 07 7777 300 0 0 134 40000000
0 0 07 1f 0 1f 0 138 0 2222 134 40000000
f

//--- verif/ctrlRegChecker.sv
`timescale 1ns/1ps

module ctrlRegChecker
(
	input	logic							clock,
	input	logic							reset,
	input	logic							stepValid,
	input	int								stepNum,
	input	logic [3:0]						stepOp,
	input	logic [crPkg::wordWidth-1:0]	expRead,
	input	logic [crPkg::addrWidth-1:0]	expPc,
	input	logic [crPkg::wordWidth-1:0]	expSr,
	input	crPkg::crId_t					readId,
	input	crPkg::crId_t					ex1Id,
	input	crPkg::crId_t					ex2Id,
	input	logic [crPkg::wordWidth-1:0]	readVal,
	input	logic [crPkg::addrWidth-1:0]	pc,
	input	logic [crPkg::wordWidth-1:0]	sr,
	input	logic [crPkg::addrWidth-1:0]	vbr,
	output	int								checkedCount,
	output	int								failedCount
);

	import crPkg::*;

	int mismatches;	// Within the current step

	function automatic string opName(input logic [3:0] op);
		case (op)
			4'h0:		return "read";
			4'h1:		return "write";
			4'h2:		return "trap";
			4'h3:		return "rte";
			4'h4:		return "hold";
			4'h5:		return "hold+trap";
			default:	return "unknown";
		endcase
	endfunction

	task automatic compareValue
	(
		input string				name,
		input logic [wordWidth-1:0]	got,
		input logic [wordWidth-1:0]	want
	);
		if (got !== want)
		begin
			$display("ERR step %0d %s: got 0x%h, expected 0x%h", stepNum, name, got, want);
			mismatches++;
		end
	endtask

	// Sample mid-cycle where inputs and registers have settled
	always @(negedge clock)
	begin
		if (reset)
		begin
			checkedCount = 0;
			failedCount = 0;
		end
		else if (stepValid)
		begin
			mismatches = 0;
			compareValue("readVal", readVal, expRead);
			compareValue("pc", wordWidth'(pc), wordWidth'(expPc));
			compareValue("sr", sr, expSr);
			// A plain VBR read gives the stored VBR
			if (readId == crVbr && ex1Id != crVbr && ex2Id != crVbr)
				compareValue("vbr", wordWidth'(vbr), expRead);
			checkedCount++;
			if (mismatches == 0)
				$display("step %0d %s ok", stepNum, opName(stepOp));
			else
			begin
				$display("step %0d %s failed, %0d mismatches", stepNum, opName(stepOp),
					mismatches);
				failedCount++;
			end
		end
	end

endmodule

//--- verif/ctrlRegTb.sv
`timescale 1ns/1ps

module ctrlRegTb;

	import crPkg::*;
	import trapPkg::*;

	localparam int fieldCount = 12;	// Hex tokens per golden step
	localparam int maxSteps = 64;
	localparam int drainLimit = 20;

	logic					clock;
	logic					reset;
	logic					hold;
	logic [addrWidth-1:0]	pcNext;
	logic [addrWidth-1:0]	lrNext;
	logic					trapReq;
	trapCause_t				trapCause;
	logic [addrWidth-1:0]	trapAddr;
	logic					rteReq;
	crId_t					readId;
	logic [wordWidth-1:0]	readVal;
	crId_t					ex1Id;
	logic [wordWidth-1:0]	ex1Val;
	crId_t					ex2Id;
	logic [wordWidth-1:0]	ex2Val;
	logic [addrWidth-1:0]	pc;
	logic [wordWidth-1:0]	sr;
	logic [addrWidth-1:0]	vbr;

	logic [63:0]			golden [0:fieldCount*maxSteps-1];
	logic					stepValid;
	int						stepNum;
	logic [3:0]				stepOp;
	logic [wordWidth-1:0]	expRead;
	logic [addrWidth-1:0]	expPc;
	logic [wordWidth-1:0]	expSr;
	int						stepCount;
	int						checkedCount;
	int						failedCount;
	int						drainCycles;

	ctrlRegTop ctrlRegTop_i
	(
		.clock(clock), .reset(reset), .hold(hold), .pcNext(pcNext), .lrNext(lrNext),
		.trapReq(trapReq), .trapCause(trapCause), .trapAddr(trapAddr), .rteReq(rteReq),
		.readId(readId), .readVal(readVal), .ex1Id(ex1Id), .ex1Val(ex1Val),
		.ex2Id(ex2Id), .ex2Val(ex2Val), .pc(pc), .sr(sr), .vbr(vbr)
	);

	ctrlRegChecker ctrlRegChecker_i
	(
		.clock(clock), .reset(reset), .stepValid(stepValid), .stepNum(stepNum),
		.stepOp(stepOp), .expRead(expRead), .expPc(expPc), .expSr(expSr),
		.readId(readId), .ex1Id(ex1Id), .ex2Id(ex2Id),
		.readVal(readVal), .pc(pc), .sr(sr), .vbr(vbr),
		.checkedCount(checkedCount), .failedCount(failedCount)
	);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// Index of the end marker line or zero without one
	function automatic int countSteps();
		for (int i = 0; i < maxSteps; i++)
			if (golden[i*fieldCount][3:0] == 4'hf)
				return i;
		return 0;
	endfunction

	task automatic driveIdle();
		hold		<= 1'b0;
		trapReq		<= 1'b0;
		rteReq		<= 1'b0;
		trapCause	<= causeReset;
		trapAddr	<= '0;
		pcNext		<= '0;
		lrNext		<= '0;
		readId		<= crZzr;
		ex1Id		<= crZzr;
		ex2Id		<= crZzr;
		ex1Val		<= '0;
		ex2Val		<= '0;
		stepValid	<= 1'b0;
	endtask

	// Op codes 0 read, 1 write, 2 trap, 3 rte, 4 hold, 5 hold with trap
	task automatic applyStep(input int step);
		int			base;
		logic [3:0]	op;
		base = step * fieldCount;
		op = golden[base][3:0];
		hold		<= (op == 4'h4 || op == 4'h5);
		trapReq		<= (op == 4'h2 || op == 4'h5);
		rteReq		<= (op == 4'h3);
		trapCause	<= trapCause_t'(golden[base+1][3:0]);
		readId		<= crId_t'(golden[base+2][4:0]);
		ex1Id		<= crId_t'(golden[base+3][4:0]);
		ex1Val		<= golden[base+4];
		ex2Id		<= crId_t'(golden[base+5][4:0]);
		ex2Val		<= golden[base+6];
		pcNext		<= golden[base+7][addrWidth-1:0];
		trapAddr	<= golden[base+8][addrWidth-1:0];
		expRead		<= golden[base+9];
		expPc		<= golden[base+10][addrWidth-1:0];
		expSr		<= golden[base+11];
		stepOp		<= op;
		stepNum		<= step;
		stepValid	<= 1'b1;
	endtask

	initial
	begin
		reset <= 1'b1;
		driveIdle();
		$readmemh("verif/ctrlGolden.txt", golden);
		stepCount = countSteps();
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		for (int i = 0; i < stepCount; i++)
		begin
			@(posedge clock);
			applyStep(i);
		end
		@(posedge clock);
		driveIdle();
		drainCycles = 0;
		while (checkedCount < stepCount && drainCycles < drainLimit)
		begin
			@(posedge clock);
			drainCycles++;
		end
		$display("Steps checked %0d of %0d, passed %0d, failed %0d", checkedCount, stepCount,
			checkedCount - failedCount, failedCount);
		if (stepCount == 0)
			$display("Golden file is empty or has no end marker");
		else if (checkedCount != stepCount)
			$display("Timed out after %0d cycles waiting for the last step check", drainCycles);
		if (stepCount == 0 || checkedCount != stepCount || failedCount != 0)
			$display("Verification failed");
		else
			$display("Verification passed");
		$finish;
	end

endmodule
